// File: compile.f
ramtest_host_pkg.sv
mem_port_pkg.sv
sync_fifo.sv
pipe_in_buffer.sv
pipe_out_buffer.sv
ddr2_test.sv
mem_port_model.sv
ramtest_core.sv
tb_ramtest.sv

// File: ddr2_test.sv
/* Test engine. Moves bursts from the input FIFO to the memory port in
   ascending addresses, and reads them back in the same order when enabled */
`timescale 1ns/1ps

module ddr2_test (
	input  logic                                okClk,
	input  logic                                rst,
	input  ramtest_host_pkg::host_ctrl_t        ctrl,
	input  logic                                calib_done,
	input  ramtest_host_pkg::fifo_status_t      in_status,
	input  logic [ramtest_host_pkg::WORD_W-1:0] in_data,
	output logic                                in_pop,
	input  ramtest_host_pkg::fifo_status_t      out_status,
	output logic                                out_push,
	output logic [ramtest_host_pkg::WORD_W-1:0] out_data,
	output logic                                cmd_en,
	output mem_port_pkg::mem_cmd_t              cmd,
	input  logic                                cmd_full,
	output mem_port_pkg::mem_wr_t               wr,
	input  logic                                wr_full,
	output logic                                rd_en,
	input  logic                                rd_empty,
	input  logic [ramtest_host_pkg::WORD_W-1:0] rd_data,
	output logic                                busy
);
	import ramtest_host_pkg::*;
	import mem_port_pkg::*;

	engine_state_e          state;
	logic [WORD_ADDR_W-1:0] wr_addr;    // Word addresses
	logic [WORD_ADDR_W-1:0] rd_addr;
	logic [BL_W-1:0]        word_cnt;   // Position within the burst
	logic                   last_word;
	logic                   wr_go;
	logic                   rd_go;

	// A full burst waiting, or room for one in the output FIFO
	assign wr_go = ctrl.writes_en && calib_done &&
		in_status.count >= COUNT_W'(BURST_LEN);
	assign rd_go = ctrl.reads_en && calib_done &&
		out_status.count <= COUNT_W'(FIFO_DEPTH - BURST_LEN);

	assign last_word = word_cnt == BL_W'(BURST_LEN - 1);

	//------------------------------------------------------------
	// Port drive
	//------------------------------------------------------------
	assign in_pop   = (state == ST_WR_FILL) && !wr_full;
	assign wr       = '{en: in_pop, data: in_data};
	assign rd_en    = (state == ST_RD_DRAIN) && !rd_empty;
	assign out_push = rd_en;     // Room was checked before the command
	assign out_data = rd_data;
	assign busy     = (state == ST_WR_FILL) || (state == ST_WR_CMD);

	assign cmd_en = (state == ST_WR_CMD) || (state == ST_RD_CMD);
	assign cmd    = '{
		instr:     (state == ST_RD_CMD) ? MEM_READ : MEM_WRITE,
		byte_addr: {(state == ST_RD_CMD) ? rd_addr : wr_addr, 2'b00},
		bl:        BL_W'(BURST_LEN - 1)
	};

	//------------------------------------------------------------
	// FSM
	//------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			state    <= ST_IDLE;
			wr_addr  <= '0;
			rd_addr  <= '0;
			word_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					word_cnt <= '0;
					if (wr_go) begin
						state <= ST_WR_FILL;     // Writes come first
					end else if (rd_go) begin
						state <= ST_RD_CMD;
					end
				end
				ST_WR_FILL: begin
					if (in_pop) begin
						word_cnt <= word_cnt + 1'b1;
						if (last_word) state <= ST_WR_CMD;
					end
				end
				ST_WR_CMD: begin
					if (!cmd_full) begin
						// Natural wrap at MEM_WORDS
						wr_addr <= wr_addr + WORD_ADDR_W'(BURST_LEN);
						state   <= ST_IDLE;
					end
				end
				ST_RD_CMD: begin
					if (!cmd_full) begin
						rd_addr <= rd_addr + WORD_ADDR_W'(BURST_LEN);
						state   <= ST_RD_DRAIN;
					end
				end
				ST_RD_DRAIN: begin
					if (rd_en) begin
						word_cnt <= word_cnt + 1'b1;
						if (last_word) state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: mem_port_model.sv
/* Behavioral burst memory port: calibration delay, command queue, write and
   read data FIFOs and a backing RAM. One command runs at a time */
`timescale 1ns/1ps

module mem_port_model (
	input  logic                                okClk,
	input  logic                                rst,
	output logic                                calib_done,
	input  logic                                cmd_en,
	input  mem_port_pkg::mem_cmd_t              cmd,
	output logic                                cmd_full,
	input  mem_port_pkg::mem_wr_t               wr,
	output logic                                wr_full,
	input  logic                                rd_en,
	output logic                                rd_empty,
	output logic [ramtest_host_pkg::WORD_W-1:0] rd_data
);
	import ramtest_host_pkg::*;
	import mem_port_pkg::*;

	logic [WORD_W-1:0]      ram [MEM_WORDS];
	logic [CAL_W-1:0]       cal_cnt;
	mem_cmd_t               cmd_q [CMD_DEPTH];
	logic [CMD_PTR_W-1:0]   cq_wr;
	logic [CMD_PTR_W-1:0]   cq_rd;
	logic [CMD_PTR_W:0]     cq_cnt;
	logic [WORD_W-1:0]      wf_mem [DFIFO_DEPTH];
	logic [DFIFO_W-1:0]     wf_wr;
	logic [DFIFO_W-1:0]     wf_rd;
	logic [DFIFO_W:0]       wf_cnt;
	logic [WORD_W-1:0]      rf_mem [DFIFO_DEPTH];
	logic [DFIFO_W-1:0]     rf_wr;
	logic [DFIFO_W-1:0]     rf_rd;
	logic [DFIFO_W:0]       rf_cnt;
	mem_cmd_t               ex_cmd;     // Command in execution
	logic                   ex_busy;
	logic [WORD_ADDR_W-1:0] ex_addr;
	logic [BL_W-1:0]        ex_idx;
	logic [LAT_W-1:0]       lat_cnt;
	logic                   ex_wr;
	logic                   ex_step;
	logic                   cq_push;
	logic                   cq_pop;
	logic                   wf_push;
	logic                   rf_pop;

	assign cmd_full = cq_cnt == (CMD_PTR_W+1)'(CMD_DEPTH);
	assign wr_full  = wf_cnt == (DFIFO_W+1)'(DFIFO_DEPTH);
	assign rd_empty = rf_cnt == '0;
	assign rd_data  = rf_mem[rf_rd];

	assign cq_push = cmd_en && !cmd_full;
	assign cq_pop  = !ex_busy && (cq_cnt != '0);
	assign wf_push = wr.en && !wr_full;
	assign rf_pop  = rd_en && !rd_empty;
	assign ex_wr   = ex_cmd.instr == MEM_WRITE;
	// One word per cycle unless the write FIFO is empty or the read FIFO full
	assign ex_step = ex_busy && (lat_cnt == '0) &&
		(ex_wr ? (wf_cnt != '0) : (rf_cnt != (DFIFO_W+1)'(DFIFO_DEPTH)));

	always_ff @(posedge okClk) begin
		if (rst) begin
			calib_done <= 1'b0;
			cal_cnt    <= '0;
			cq_wr      <= '0;
			cq_rd      <= '0;
			cq_cnt     <= '0;
			wf_wr      <= '0;
			wf_rd      <= '0;
			wf_cnt     <= '0;
			rf_wr      <= '0;
			rf_rd      <= '0;
			rf_cnt     <= '0;
		end else begin
			if (!calib_done) begin
				cal_cnt <= cal_cnt + 1'b1;
				if (cal_cnt == CAL_W'(CALIB_CYCLES - 1)) calib_done <= 1'b1;
			end
			if (cq_push) cq_wr <= cq_wr + 1'b1;
			if (cq_pop) cq_rd <= cq_rd + 1'b1;
			cq_cnt <= cq_cnt + {{CMD_PTR_W{1'b0}}, cq_push} - {{CMD_PTR_W{1'b0}}, cq_pop};
			if (wf_push) wf_wr <= wf_wr + 1'b1;
			if (ex_step && ex_wr) wf_rd <= wf_rd + 1'b1;
			wf_cnt <= wf_cnt + {{DFIFO_W{1'b0}}, wf_push} -
				{{DFIFO_W{1'b0}}, ex_step && ex_wr};
			if (ex_step && !ex_wr) rf_wr <= rf_wr + 1'b1;
			if (rf_pop) rf_rd <= rf_rd + 1'b1;
			rf_cnt <= rf_cnt + {{DFIFO_W{1'b0}}, ex_step && !ex_wr} -
				{{DFIFO_W{1'b0}}, rf_pop};
		end
	end

	//------------------------------------------------------------
	// Command execution
	//------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			ex_busy <= 1'b0;
			lat_cnt <= '0;
		end else if (cq_pop) begin
			ex_busy <= 1'b1;
			ex_cmd  <= cmd_q[cq_rd];
			ex_addr <= cmd_q[cq_rd].byte_addr[ADDR_W-1:2];
			ex_idx  <= '0;
			// Queue and FIFO stages make up the rest of the read latency
			lat_cnt <= (cmd_q[cq_rd].instr == MEM_READ) ? LAT_W'(READ_LATENCY - 3) : '0;
		end else if (lat_cnt != '0) begin
			lat_cnt <= lat_cnt - 1'b1;
		end else if (ex_step) begin
			ex_addr <= ex_addr + 1'b1;   // Wraps within MEM_WORDS
			ex_idx  <= ex_idx + 1'b1;
			if (ex_idx == ex_cmd.bl) ex_busy <= 1'b0;
		end
	end

	// Queue, data FIFO and RAM arrays
	always_ff @(posedge okClk) begin
		if (cq_push) cmd_q[cq_wr] <= cmd;
		if (wf_push) wf_mem[wf_wr] <= wr.data;
		if (ex_step && ex_wr) ram[ex_addr] <= wf_mem[wf_rd];
		if (ex_step && !ex_wr) rf_mem[rf_wr] <= ram[ex_addr];
	end

endmodule

// File: mem_port_pkg.sv
/* Memory-port definitions: geometry of the backing memory, the command and
   write-data formats of the burst port, and the engine state encoding */

package mem_port_pkg;

	localparam int MEM_WORDS    = 512;
	localparam int WORD_ADDR_W  = $clog2(MEM_WORDS);
	localparam int BURST_LEN    = 32;               // Words per command
	localparam int BL_W         = $clog2(BURST_LEN);
	localparam int ADDR_W       = 11;               // Byte address
	localparam int READ_LATENCY = 4;
	localparam int LAT_W        = $clog2(READ_LATENCY);
	localparam int CALIB_CYCLES = 16;
	localparam int CAL_W        = $clog2(CALIB_CYCLES);
	localparam int CMD_DEPTH    = 4;
	localparam int CMD_PTR_W    = $clog2(CMD_DEPTH);
	localparam int DFIFO_DEPTH  = BURST_LEN * 2;    // Write and read data FIFOs
	localparam int DFIFO_W      = $clog2(DFIFO_DEPTH);

	typedef enum logic [2:0] {
		MEM_WRITE = 3'b000,
		MEM_READ  = 3'b001
	} mem_instr_e;

	typedef struct packed {
		mem_instr_e        instr;
		logic [ADDR_W-1:0] byte_addr;
		logic [BL_W-1:0]   bl;         // Burst length minus one
	} mem_cmd_t;

	typedef struct packed {
		logic                                en;
		logic [ramtest_host_pkg::WORD_W-1:0] data;
	} mem_wr_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WR_FILL,
		ST_WR_CMD,
		ST_RD_CMD,
		ST_RD_DRAIN
	} engine_state_e;

endpackage

// File: pipe_in_buffer.sv
/* Input side of the host pipe. Buffers host words for the engine and
   raises pi_ready while a whole block still fits */
`timescale 1ns/1ps

module pipe_in_buffer (
	input  logic                                okClk,
	input  logic                                rst,
	input  logic                                pi_write,
	input  logic [ramtest_host_pkg::WORD_W-1:0] pi_data,
	output logic                                pi_ready,
	input  logic                                in_pop,
	output logic [ramtest_host_pkg::WORD_W-1:0] in_data,
	output ramtest_host_pkg::fifo_status_t      in_status
);
	import ramtest_host_pkg::*;

	sync_fifo u_fifo (
		.okClk     (okClk),
		.rst       (rst),
		.push      (pi_write),
		.push_data (pi_data),
		.pop       (in_pop),
		.head      (in_data),
		.status    (in_status)
	);

	//------------------------------------------------------------
	// Block throttle
	//------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			pi_ready <= 1'b0;
		end else begin
			// Reduced limit covers the count update delay
			pi_ready <= in_status.count <=
				COUNT_W'(FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE);
		end
	end

endmodule

// File: pipe_out_buffer.sv
/* Output side of the host pipe. Holds read-back words from the engine and
   raises po_ready once a whole block can be fetched */
`timescale 1ns/1ps

module pipe_out_buffer (
	input  logic                                okClk,
	input  logic                                rst,
	input  logic                                out_push,
	input  logic [ramtest_host_pkg::WORD_W-1:0] out_data,
	output ramtest_host_pkg::fifo_status_t      out_status,
	input  logic                                po_read,
	output logic [ramtest_host_pkg::WORD_W-1:0] po_data,
	output logic                                po_ready
);
	import ramtest_host_pkg::*;

	sync_fifo u_fifo (
		.okClk     (okClk),
		.rst       (rst),
		.push      (out_push),
		.push_data (out_data),
		.pop       (po_read),
		.head      (po_data),
		.status    (out_status)
	);

	//------------------------------------------------------------
	// Block available
	//------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			po_ready <= 1'b0;
		end else begin
			po_ready <= out_status.count >= COUNT_W'(BLOCK_SIZE);
		end
	end

endmodule

// File: ramtest_core.sv
/* Top level of the loopback test. Connects the host pipe buffers, the test
   engine and the memory port; soft reset clears all but the RAM contents */
`timescale 1ns/1ps

module ramtest_core (
	input  logic                                okClk,
	input  logic                                rst,
	input  ramtest_host_pkg::host_ctrl_t        ctrl,
	input  logic                                pi_write,
	input  logic [ramtest_host_pkg::WORD_W-1:0] pi_data,
	output logic                                pi_ready,
	input  logic                                po_read,
	output logic [ramtest_host_pkg::WORD_W-1:0] po_data,
	output logic                                po_ready,
	output ramtest_host_pkg::ramtest_status_t   status
);
	import ramtest_host_pkg::*;
	import mem_port_pkg::*;

	logic              core_rst;
	fifo_status_t      in_status;
	fifo_status_t      out_status;
	logic [WORD_W-1:0] in_data;
	logic [WORD_W-1:0] out_data;
	logic [WORD_W-1:0] rd_data;
	logic              in_pop;
	logic              out_push;
	logic              calib_done;
	logic              cmd_en;
	logic              cmd_full;
	logic              wr_full;
	logic              rd_en;
	logic              rd_empty;
	logic              busy;
	mem_cmd_t          cmd;
	mem_wr_t           wr;

	assign core_rst = rst | ctrl.soft_reset;

	//------------------------------------------------------------
	// Datapath
	//------------------------------------------------------------
	pipe_in_buffer u_pipe_in (
		.okClk(okClk), .rst(core_rst), .pi_write(pi_write), .pi_data(pi_data),
		.pi_ready(pi_ready), .in_pop(in_pop), .in_data(in_data), .in_status(in_status)
	);

	ddr2_test u_engine (
		.okClk(okClk), .rst(core_rst), .ctrl(ctrl), .calib_done(calib_done),
		.in_status(in_status), .in_data(in_data), .in_pop(in_pop),
		.out_status(out_status), .out_push(out_push), .out_data(out_data),
		.cmd_en(cmd_en), .cmd(cmd), .cmd_full(cmd_full), .wr(wr), .wr_full(wr_full),
		.rd_en(rd_en), .rd_empty(rd_empty), .rd_data(rd_data), .busy(busy)
	);

	mem_port_model u_mem (
		.okClk(okClk), .rst(core_rst), .calib_done(calib_done),
		.cmd_en(cmd_en), .cmd(cmd), .cmd_full(cmd_full), .wr(wr), .wr_full(wr_full),
		.rd_en(rd_en), .rd_empty(rd_empty), .rd_data(rd_data)
	);

	pipe_out_buffer u_pipe_out (
		.okClk(okClk), .rst(core_rst), .out_push(out_push), .out_data(out_data),
		.out_status(out_status), .po_read(po_read), .po_data(po_data),
		.po_ready(po_ready)
	);

	assign status = '{
		pi_full:    in_status.full,
		pi_empty:   in_status.empty,
		po_full:    out_status.full,
		po_empty:   out_status.empty,
		calib_done: calib_done,
		wr_busy:    busy
	};

endmodule

// File: ramtest_host_pkg.sv
/* Host-side definitions for the loopback test: the wire-in control word,
   pipe FIFO status and the block sizes that govern the block-throttle flags */

package ramtest_host_pkg;

	localparam int WORD_W          = 32;
	localparam int FIFO_DEPTH      = 256;              // Words per pipe FIFO
	localparam int PTR_W           = $clog2(FIFO_DEPTH);
	localparam int COUNT_W         = 9;                // Holds 0..FIFO_DEPTH
	localparam int BLOCK_SIZE      = 64;               // One host block in words
	localparam int BUFFER_HEADROOM = 4;                // Slack for count update delay

	// Wire-in control word with reads_en in bit 0
	typedef struct packed {
		logic soft_reset;
		logic writes_en;
		logic reads_en;
	} host_ctrl_t;

	typedef struct packed {
		logic               full;
		logic               empty;
		logic [COUNT_W-1:0] count;
	} fifo_status_t;

	// Flags gathered for the host
	typedef struct packed {
		logic pi_full;
		logic pi_empty;
		logic po_full;
		logic po_empty;
		logic calib_done;
		logic wr_busy;
	} ramtest_status_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build the loopback testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_ramtest -o sim_ramtest \
	&& ./obj_dir/sim_ramtest | tee /dev/stderr | grep -qx "Test OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: sync_fifo.sv
/* Show-ahead single-clock FIFO with a registered occupancy count.
   The head word is valid whenever status.empty is low */
`timescale 1ns/1ps

module sync_fifo (
	input  logic                                okClk,
	input  logic                                rst,
	input  logic                                push,
	input  logic [ramtest_host_pkg::WORD_W-1:0] push_data,
	input  logic                                pop,
	output logic [ramtest_host_pkg::WORD_W-1:0] head,
	output ramtest_host_pkg::fifo_status_t      status
);
	import ramtest_host_pkg::*;

	logic [WORD_W-1:0]  mem [FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic               do_push;
	logic               do_pop;
	logic [COUNT_W-1:0] count_next;

	assign do_push = push && !status.full;   // Push while full is dropped
	assign do_pop  = pop && !status.empty;
	assign head    = mem[rd_ptr];

	always_comb begin
		unique case ({do_push, do_pop})
			2'b10:   count_next = status.count + 1'b1;
			2'b01:   count_next = status.count - 1'b1;
			default: count_next = status.count;
		endcase
	end

	always_ff @(posedge okClk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			status <= '{full: 1'b0, empty: 1'b1, count: '0};
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			// Flags follow the new count
			status.count <= count_next;
			status.full  <= count_next == COUNT_W'(FIFO_DEPTH);
			status.empty <= count_next == '0;
		end
	end

	always_ff @(posedge okClk) begin
		if (do_push) mem[wr_ptr] <= push_data;
	end

endmodule

// File: tb_ramtest.sv
/* Testbench for the loopback core. Applies a table of host steps through the
   pipe endpoints and checks read-back data against a reference memory model */
`timescale 1ns/1ps

module tb_ramtest;
	import ramtest_host_pkg::*;
	import mem_port_pkg::*;

	localparam int TIMEOUT     = 2000;
	localparam int TOTAL_WORDS = 2048;
	localparam int ROUND       = FIFO_DEPTH / BLOCK_SIZE;    // Blocks in a full output FIFO
	localparam int THROTTLE_AT = FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE;
	localparam int NUM_STEPS   = 5;

	typedef enum logic [2:0] {
		STEP_IDLE,
		STEP_LOOPBACK,
		STEP_THROTTLE,
		STEP_WRAP,
		STEP_SOFT_RESET
	} step_kind_e;

	typedef enum logic [2:0] {
		C_CALIB,
		C_PI_READY,
		C_PO_READY,
		C_PO_FULL,
		C_WR_DONE
	} cond_e;

	typedef struct packed {
		step_kind_e  kind;
		host_ctrl_t  ctrl;
		logic [7:0]  n_send;       // Blocks
		logic [7:0]  n_fetch;
		logic [15:0] exp_offset;   // Host word number of the first fetched word
	} step_t;

	localparam host_ctrl_t CTRL_OFF = '{soft_reset: 1'b0, writes_en: 1'b0, reads_en: 1'b0};
	localparam host_ctrl_t CTRL_WR  = '{soft_reset: 1'b0, writes_en: 1'b1, reads_en: 1'b0};
	localparam host_ctrl_t CTRL_RD  = '{soft_reset: 1'b0, writes_en: 1'b0, reads_en: 1'b1};

	logic              okClk;
	logic              rst;
	host_ctrl_t        ctrl;
	logic              pi_write;
	logic [WORD_W-1:0] pi_data;
	logic              pi_ready;
	logic              po_read;
	logic [WORD_W-1:0] po_data;
	logic              po_ready;
	ramtest_status_t   status;

	step_t             steps [NUM_STEPS];
	logic [WORD_W-1:0] ref_words [TOTAL_WORDS];
	int                mem_ref [MEM_WORDS];    // Host word number held at each address
	int                mdl_wr;
	int                mdl_rd;
	int                next_word;
	int                n_checks;
	int                n_errors;

	ramtest_core u_dut (
		.okClk    (okClk),
		.rst      (rst),
		.ctrl     (ctrl),
		.pi_write (pi_write),
		.pi_data  (pi_data),
		.pi_ready (pi_ready),
		.po_read  (po_read),
		.po_data  (po_data),
		.po_ready (po_ready),
		.status   (status)
	);

	initial begin
		okClk = 1'b0;
		forever #5 okClk = ~okClk;
	end

	//------------------------------------------------------------
	// Compare tasks
	//------------------------------------------------------------
	task automatic check_word(input string name, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] exp_word);
		n_checks++;
		if (got !== exp_word) begin
			n_errors++;
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp_word);
		end
	endtask

	task automatic check_status(input string name, input ramtest_status_t got,
			input ramtest_status_t exp_status);
		n_checks++;
		if (got !== exp_status) begin
			n_errors++;
			$display("Error at %0t: %s = %b, expected %b", $time, name, got, exp_status);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp_flag);
		n_checks++;
		if (got !== exp_flag) begin
			n_errors++;
			$display("Error at %0t: %s = %b, expected %b", $time, name, got, exp_flag);
		end
	endtask

	function automatic ramtest_status_t empty_status(input logic calib);
		ramtest_status_t s;
		s = '{pi_full: 1'b0, pi_empty: 1'b1, po_full: 1'b0, po_empty: 1'b1,
			calib_done: calib, wr_busy: 1'b0};
		return s;
	endfunction

	//------------------------------------------------------------
	// Waits and host pipe model
	//------------------------------------------------------------
	function automatic logic cond_met(input cond_e c);
		case (c)
			C_CALIB:    return status.calib_done;
			C_PI_READY: return pi_ready;
			C_PO_READY: return po_ready;
			C_PO_FULL:  return status.po_full;
			default:    return status.pi_empty && !status.wr_busy;    // Input drained
		endcase
	endfunction

	task automatic wait_until(input cond_e c, input string what);
		int n;
		n = 0;
		do begin
			@(negedge okClk);    // Outputs are settled here
			n++;
		end while (!cond_met(c) && n < TIMEOUT);
		if (!cond_met(c)) begin
			$display("Timeout: gave up waiting for %s after %0d cycles", what, TIMEOUT);
			$display("Test FAILED");
			$finish;
		end
	endtask

	task automatic send_block();
		int i;
		wait_until(C_PI_READY, "pi_ready before sending a block");
		for (i = 0; i < BLOCK_SIZE; i++) begin
			@(posedge okClk);
			pi_write <= 1'b1;
			pi_data  <= ref_words[next_word];
			next_word++;
		end
		@(posedge okClk);
		pi_write <= 1'b0;
	endtask

	// Words reach memory in ascending addresses, wrapping at MEM_WORDS
	task automatic commit_words(input int first, input int n);
		int i;
		for (i = 0; i < n; i++) begin
			mem_ref[mdl_wr] = first + i;
			mdl_wr = (mdl_wr + 1) % MEM_WORDS;
		end
	endtask

	task automatic fetch_block(input logic first, input int exp_offset);
		int                i;
		logic [WORD_W-1:0] exp_word;
		wait_until(C_PO_READY, "po_ready before fetching a block");
		for (i = 0; i < BLOCK_SIZE; i++) begin
			@(posedge okClk);
			po_read <= 1'b1;
			@(negedge okClk);    // Head word i is popped at the next edge
			if (first && i == 0) begin
				check_word("po_data at start offset", po_data, ref_words[exp_offset]);
			end
			exp_word = ref_words[mem_ref[mdl_rd]];
			mdl_rd   = (mdl_rd + 1) % MEM_WORDS;
			check_word("po_data", po_data, exp_word);
		end
		@(posedge okClk);
		po_read <= 1'b0;
	endtask

	task automatic fetch_blocks(input int n, input host_ctrl_t base, input int exp_offset);
		int         b;
		host_ctrl_t rd_ctrl;
		host_ctrl_t idle_ctrl;
		rd_ctrl            = base;
		rd_ctrl.reads_en   = 1'b1;
		idle_ctrl          = base;
		idle_ctrl.reads_en = 1'b0;
		for (b = 0; b < n; b++) begin
			if (b % ROUND == 0) begin
				// Fill the output FIFO, then stop reads so the address stays known
				@(posedge okClk);
				ctrl <= rd_ctrl;
				wait_until(C_PO_FULL, "output FIFO to fill");
				@(posedge okClk);
				ctrl <= idle_ctrl;
			end
			fetch_block(b == 0, exp_offset);
		end
	endtask

	task automatic pulse_soft_reset();
		@(posedge okClk);
		ctrl <= '{soft_reset: 1'b1, writes_en: 1'b0, reads_en: 1'b0};
		repeat (2) @(posedge okClk);
		ctrl   <= CTRL_OFF;
		mdl_wr = 0;     // Engine addresses restart while RAM keeps its words
		mdl_rd = 0;
	endtask

	//------------------------------------------------------------
	// Step bodies
	//------------------------------------------------------------
	task automatic run_idle();
		wait_until(C_CALIB, "calibration after reset");
		check_flag("pi_ready", pi_ready, 1'b1);
		check_status("status", status, empty_status(1'b1));
		repeat (50) begin
			@(negedge okClk);
			check_flag("po_ready", po_ready, 1'b0);    // No data while reads are off
		end
	endtask

	task automatic run_loopback(input step_t s);
		int first;
		if (s.kind == STEP_WRAP) pulse_soft_reset();
		@(posedge okClk);
		ctrl  <= s.ctrl;
		first = next_word;
		repeat (s.n_send) send_block();
		wait_until(C_WR_DONE, "engine to drain the input FIFO");
		commit_words(first, s.n_send * BLOCK_SIZE);
		fetch_blocks(s.n_fetch, s.ctrl, s.exp_offset);
	endtask

	task automatic run_throttle(input step_t s);
		int   b;
		int   first;
		logic exp_ready;
		@(posedge okClk);
		ctrl  <= s.ctrl;
		first = next_word;
		for (b = 0; b < s.n_send; b++) begin
			send_block();
			repeat (2) @(negedge okClk);    // Registered ready catches up
			exp_ready = (b + 1) * BLOCK_SIZE <= THROTTLE_AT;
			check_flag("pi_ready", pi_ready, exp_ready);
		end
		// Engine drains the input and reopens the throttle
		@(posedge okClk);
		ctrl <= CTRL_WR;
		wait_until(C_PI_READY, "pi_ready to return after writes enabled");
		wait_until(C_WR_DONE, "engine to drain the input FIFO");
		commit_words(first, s.n_send * BLOCK_SIZE);
	endtask

	task automatic run_soft_reset(input step_t s);
		@(posedge okClk);
		ctrl <= s.ctrl;
		repeat (s.n_send) send_block();    // Stays in the input FIFO
		wait_until(C_PO_FULL, "output FIFO to fill before soft reset");
		check_flag("status.pi_empty", status.pi_empty, 1'b0);
		pulse_soft_reset();
		@(negedge okClk);
		check_status("status", status, empty_status(1'b0));
		check_flag("po_ready", po_ready, 1'b0);
		fetch_blocks(s.n_fetch, CTRL_OFF, s.exp_offset);
	endtask

	function automatic string step_name(input step_kind_e kind);
		case (kind)
			STEP_IDLE:     return "idle after reset";
			STEP_LOOPBACK: return "loopback";
			STEP_THROTTLE: return "block throttle";
			STEP_WRAP:     return "address wrap";
			default:       return "soft reset";
		endcase
	endfunction

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial begin
		int    i;
		int    k;
		int    step_err;
		step_t s;
		rst       = 1'b1;
		ctrl      = CTRL_OFF;
		pi_write  = 1'b0;
		pi_data   = '0;
		po_read   = 1'b0;
		n_checks  = 0;
		n_errors  = 0;
		next_word = 0;
		mdl_wr    = 0;
		mdl_rd    = 0;
		void'($urandom(32'h300e_19aa));
		for (i = 0; i < TOTAL_WORDS; i++) ref_words[i] = $urandom();

		// Words 0..447 go first, so the wrap step sends 448..1087 and
		// address 0 ends up holding word 448 + 512
		steps[0] = '{kind: STEP_IDLE, ctrl: CTRL_OFF, n_send: 8'd0, n_fetch: 8'd0,
			exp_offset: 16'd0};
		steps[1] = '{kind: STEP_LOOPBACK, ctrl: CTRL_WR, n_send: 8'd4, n_fetch: 8'd4,
			exp_offset: 16'd0};
		steps[2] = '{kind: STEP_THROTTLE, ctrl: CTRL_OFF, n_send: 8'd3, n_fetch: 8'd0,
			exp_offset: 16'd0};
		steps[3] = '{kind: STEP_WRAP, ctrl: CTRL_WR, n_send: 8'd10, n_fetch: 8'd8,
			exp_offset: 16'd960};
		steps[4] = '{kind: STEP_SOFT_RESET, ctrl: CTRL_RD, n_send: 8'd1, n_fetch: 8'd4,
			exp_offset: 16'd960};

		repeat (2) @(posedge okClk);
		rst <= 1'b0;

		for (k = 0; k < NUM_STEPS; k++) begin
			s        = steps[k];
			step_err = n_errors;
			case (s.kind)
				STEP_IDLE:       run_idle();
				STEP_THROTTLE:   run_throttle(s);
				STEP_SOFT_RESET: run_soft_reset(s);
				default:         run_loopback(s);
			endcase
			$display("Step %0d %s: %0d errors", k, step_name(s.kind), n_errors - step_err);
		end

		$display("Steps: %0d, checks: %0d, errors: %0d", NUM_STEPS, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
